// ==== verilog/dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// read ports sharing the arrays
`define DCACHE_NUM_PORTS 3

// associativity
`define DCACHE_WAYS 2

// sets per way
`define DCACHE_SETS 16

// tag field width
`define DCACHE_TAG_W 8

// data word width, multiple of 8
`define DCACHE_WORD_W 32

// words per line, one SRAM bank each
`define DCACHE_NUM_BANKS 4

`endif

// ==== verilog/dcache_geom_pkg.sv ====
`include "dcache_cfg.svh"

package dcache_geom_pkg;

  ////////////////////////////////////////
  // address geometry
  ////////////////////////////////////////

  localparam int unsigned WordBytes = `DCACHE_WORD_W / 8;
  localparam int unsigned ByteOffW  = $clog2(WordBytes);
  localparam int unsigned BankSelW  = $clog2(`DCACHE_NUM_BANKS);
  localparam int unsigned OffW      = ByteOffW + BankSelW;
  localparam int unsigned IdxW      = $clog2(`DCACHE_SETS);
  localparam int unsigned PortIdxW  = $clog2(`DCACHE_NUM_PORTS);

  typedef logic [`DCACHE_TAG_W-1:0] tag_t;
  typedef logic [IdxW-1:0]          idx_t;
  typedef logic [OffW-1:0]          off_t;
  typedef logic [BankSelW-1:0]      bank_sel_t;

  // words and lines
  typedef logic [`DCACHE_WORD_W-1:0] word_t;
  typedef logic [WordBytes-1:0]      word_be_t;
  typedef word_t    [`DCACHE_NUM_BANKS-1:0] line_t;
  typedef word_be_t [`DCACHE_NUM_BANKS-1:0] line_be_t;

  typedef logic [`DCACHE_WAYS-1:0]      way_vec_t;
  typedef logic [`DCACHE_NUM_PORTS-1:0] port_vec_t;
  typedef logic [PortIdxW-1:0]          port_idx_t;

  // one tag array word
  typedef struct packed {
    logic vld;
    tag_t tag;
  } tag_entry_t;

  // one data bank word, same offset of every way
  typedef word_t    [`DCACHE_WAYS-1:0] way_words_t;
  typedef word_be_t [`DCACHE_WAYS-1:0] way_be_t;

  // word offset within the line selects the bank
  function automatic bank_sel_t bank_of(off_t off);
    return off[OffW-1:ByteOffW];
  endfunction

endpackage

// ==== verilog/dcache_port_pkg.sv ====
`include "dcache_cfg.svh"

package dcache_port_pkg;

  ////////////////////////////////////////
  // port side
  ////////////////////////////////////////

  // read request, the tag follows one cycle after the grant
  typedef struct packed {
    dcache_geom_pkg::idx_t idx;
    dcache_geom_pkg::off_t off;
    logic                  tag_only;
    logic                  prio;
  } rd_req_t;

  typedef struct packed {
    dcache_geom_pkg::way_vec_t vld_bits;
    dcache_geom_pkg::way_vec_t hit_oh;
    dcache_geom_pkg::word_t    data;
  } rd_rsp_t;

  // full line refill
  typedef struct packed {
    logic                      vld;
    dcache_geom_pkg::way_vec_t we;
    dcache_geom_pkg::tag_t     tag;
    dcache_geom_pkg::idx_t     idx;
    dcache_geom_pkg::line_t    data;
    dcache_geom_pkg::line_be_t be;
    dcache_geom_pkg::way_vec_t vld_bits;
  } cl_wr_t;

  // single word write, no tag access
  typedef struct packed {
    dcache_geom_pkg::way_vec_t req;
    dcache_geom_pkg::idx_t     idx;
    dcache_geom_pkg::off_t     off;
    dcache_geom_pkg::word_t    data;
    dcache_geom_pkg::word_be_t be;
  } word_wr_t;

  ////////////////////////////////////////
  // array side
  ////////////////////////////////////////

  typedef struct packed {
    logic                        req;
    logic                        we;
    dcache_geom_pkg::idx_t       idx;
    dcache_geom_pkg::way_be_t    be;
    dcache_geom_pkg::way_words_t wdata;
  } bank_cmd_t;

  // valid bit and tag to store for each way
  typedef struct packed {
    dcache_geom_pkg::way_vec_t                     req;
    logic                                          we;
    dcache_geom_pkg::idx_t                         idx;
    dcache_geom_pkg::tag_entry_t [`DCACHE_WAYS-1:0] wdata;
  } tag_cmd_t;

endpackage

// ==== verilog/dcache_sram.sv ====
`timescale 1ns/1ps

module dcache_sram #(
  parameter int unsigned NumWords  = 16,
  parameter type         payload_t = logic [31:0]
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                req_i,
  input  logic                                we_i,
  input  dcache_geom_pkg::idx_t               addr_i,
  input  payload_t                            wdata_i,
  input  logic [($bits(payload_t)+7)/8-1:0]   be_i,
  output payload_t                            rdata_o
);

  localparam int unsigned DataW = $bits(payload_t);

  logic [DataW-1:0] mem_q [NumWords];
  logic [DataW-1:0] wdata_bits;
  logic [DataW-1:0] bit_mask;
  logic [DataW-1:0] rdata_q;

  assign wdata_bits = wdata_i;

  // expand byte enables to bits, the top byte may be partial
  always_comb begin : p_mask
    for (int unsigned i = 0; i < DataW; i++) begin
      bit_mask[i] = be_i[i/8];
    end
  end

  always_ff @(posedge clk_i) begin : p_array
    if (req_i && we_i) begin
      mem_q[addr_i] <= (mem_q[addr_i] & ~bit_mask) | (wdata_bits & bit_mask);
    end
  end

  // output register only moves on a read
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rdata
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = payload_t'(rdata_q);

endmodule

// ==== verilog/dcache_port_arbiter.sv ====
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_port_arbiter (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  dcache_geom_pkg::port_vec_t rd_valid_i,
  input  dcache_geom_pkg::port_vec_t rd_prio_i,
  input  logic                       block_i,
  output dcache_geom_pkg::port_vec_t gnt_o,
  output logic                       gnt_valid_o,
  output dcache_geom_pkg::port_idx_t gnt_idx_o
);

  dcache_geom_pkg::port_vec_t req_prio;
  dcache_geom_pkg::port_vec_t req_masked;
  dcache_geom_pkg::port_idx_t ptr_d;
  dcache_geom_pkg::port_idx_t ptr_q;
  dcache_geom_pkg::port_idx_t pick_idx;
  logic                       pick_found;

  ////////////////////////////////////////
  // priority masking
  ////////////////////////////////////////

  // any high prio request shuts out the low prio ones
  assign req_prio   = rd_valid_i & rd_prio_i;
  assign req_masked = (|req_prio) ? req_prio : rd_valid_i;

  ////////////////////////////////////////
  // round robin
  ////////////////////////////////////////

  // first competing port at or after the pointer
  always_comb begin : p_pick
    int unsigned cand;
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int unsigned i = 0; i < `DCACHE_NUM_PORTS; i++) begin
      cand = (32'(ptr_q) + i) % `DCACHE_NUM_PORTS;
      if (!pick_found && req_masked[cand]) begin
        pick_found = 1'b1;
        pick_idx   = dcache_geom_pkg::port_idx_t'(cand);
      end
    end
  end

  // a refill holds off every grant
  assign gnt_valid_o = pick_found & ~block_i;
  assign gnt_idx_o   = gnt_valid_o ? pick_idx : '0;

  always_comb begin : p_gnt
    gnt_o = '0;
    if (gnt_valid_o) begin
      gnt_o[pick_idx] = 1'b1;
    end
  end

  // pointer moves past the granted port
  always_comb begin : p_ptr
    ptr_d = ptr_q;
    if (gnt_valid_o) begin
      if (pick_idx == `DCACHE_NUM_PORTS - 1) begin
        ptr_d = '0;
      end else begin
        ptr_d = pick_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptr_q
    if (!rst_ni) begin
      ptr_q <= '0;
    end else begin
      ptr_q <= ptr_d;
    end
  end

endmodule

// ==== verilog/dcache_bank_ctrl.sv ====
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_bank_ctrl (
  input  logic                                            gnt_valid_i,
  input  dcache_port_pkg::rd_req_t                        gnt_req_i,
  input  dcache_port_pkg::cl_wr_t                         cl_wr_i,
  input  dcache_port_pkg::word_wr_t                       word_wr_i,
  output logic                                            word_ack_o,
  output dcache_port_pkg::bank_cmd_t [`DCACHE_NUM_BANKS-1:0] bank_cmd_o,
  output dcache_port_pkg::tag_cmd_t                       tag_cmd_o
);

  dcache_geom_pkg::bank_sel_t rd_bank;
  dcache_geom_pkg::bank_sel_t wr_bank;
  logic                       rd_data;
  logic                       collision;

  assign rd_bank = dcache_geom_pkg::bank_of(gnt_req_i.off);
  assign wr_bank = dcache_geom_pkg::bank_of(word_wr_i.off);

  // only a data read occupies a bank, tag-only reads leave them free
  assign rd_data   = gnt_valid_i & ~gnt_req_i.tag_only;
  assign collision = rd_data & (rd_bank == wr_bank);

  assign word_ack_o = (|word_wr_i.req) & ~cl_wr_i.vld & ~collision;

  ////////////////////////////////////////
  // array commands
  ////////////////////////////////////////

  always_comb begin : p_cmd
    for (int unsigned k = 0; k < `DCACHE_NUM_BANKS; k++) begin
      bank_cmd_o[k]     = '0;
      bank_cmd_o[k].idx = word_wr_i.idx;
      for (int unsigned w = 0; w < `DCACHE_WAYS; w++) begin
        bank_cmd_o[k].wdata[w] = word_wr_i.data;
      end
    end

    tag_cmd_o     = '0;
    tag_cmd_o.idx = gnt_req_i.idx;
    for (int unsigned w = 0; w < `DCACHE_WAYS; w++) begin
      tag_cmd_o.wdata[w].vld = cl_wr_i.vld_bits[w];
      tag_cmd_o.wdata[w].tag = cl_wr_i.tag;
    end

    if (cl_wr_i.vld) begin
      // refill owns every array this cycle
      tag_cmd_o.req = cl_wr_i.we;
      tag_cmd_o.we  = 1'b1;
      tag_cmd_o.idx = cl_wr_i.idx;
      if (|cl_wr_i.we) begin
        for (int unsigned k = 0; k < `DCACHE_NUM_BANKS; k++) begin
          bank_cmd_o[k].req = 1'b1;
          bank_cmd_o[k].we  = 1'b1;
          bank_cmd_o[k].idx = cl_wr_i.idx;
          for (int unsigned w = 0; w < `DCACHE_WAYS; w++) begin
            bank_cmd_o[k].be[w]    = cl_wr_i.we[w] ? cl_wr_i.be[k] : '0;
            bank_cmd_o[k].wdata[w] = cl_wr_i.data[k];
          end
        end
      end
    end else begin
      // a grant reads the tags of all ways
      if (gnt_valid_i) begin
        tag_cmd_o.req = '1;
      end
      if (rd_data) begin
        bank_cmd_o[rd_bank].req = 1'b1;
        bank_cmd_o[rd_bank].idx = gnt_req_i.idx;
      end
      // word write only lands on a free bank
      if (word_ack_o) begin
        bank_cmd_o[wr_bank].req = 1'b1;
        bank_cmd_o[wr_bank].we  = 1'b1;
        for (int unsigned w = 0; w < `DCACHE_WAYS; w++) begin
          bank_cmd_o[wr_bank].be[w] = word_wr_i.req[w] ? word_wr_i.be : '0;
        end
      end
    end
  end

endmodule

// ==== verilog/dcache_hit_select.sv ====
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_hit_select (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic                                               gnt_valid_i,
  input  logic                                               gnt_tag_only_i,
  input  dcache_geom_pkg::port_idx_t                         gnt_idx_i,
  input  dcache_geom_pkg::off_t                              gnt_off_i,
  input  dcache_geom_pkg::tag_t [`DCACHE_NUM_PORTS-1:0]      rd_tag_i,
  input  dcache_geom_pkg::tag_entry_t [`DCACHE_WAYS-1:0]     tag_rdata_i,
  input  dcache_geom_pkg::way_words_t [`DCACHE_NUM_BANKS-1:0] bank_rdata_i,
  output dcache_port_pkg::rd_rsp_t                           rd_rsp_o
);

  logic                        cmp_en_q;
  logic                        tag_only_q;
  dcache_geom_pkg::port_idx_t  port_q;
  dcache_geom_pkg::bank_sel_t  bank_q;
  dcache_geom_pkg::tag_t       late_tag;
  dcache_geom_pkg::way_words_t way_words;

  // request side state for the compare cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_stage
    if (!rst_ni) begin
      cmp_en_q   <= 1'b0;
      tag_only_q <= 1'b0;
      port_q     <= '0;
      bank_q     <= '0;
    end else begin
      cmp_en_q   <= gnt_valid_i;
      tag_only_q <= gnt_tag_only_i;
      port_q     <= gnt_idx_i;
      bank_q     <= dcache_geom_pkg::bank_of(gnt_off_i);
    end
  end

  // tag of the granted port arrives now
  assign late_tag  = rd_tag_i[port_q];
  assign way_words = bank_rdata_i[bank_q];

  ////////////////////////////////////////
  // compare and readout
  ////////////////////////////////////////

  always_comb begin : p_hit
    int unsigned hit_way;
    hit_way = 0;
    for (int unsigned w = 0; w < `DCACHE_WAYS; w++) begin
      rd_rsp_o.vld_bits[w] = tag_rdata_i[w].vld;
      rd_rsp_o.hit_oh[w]   = cmp_en_q & tag_rdata_i[w].vld & (tag_rdata_i[w].tag == late_tag);
    end
    // lowest hitting way, way 0 on a miss
    for (int unsigned w = `DCACHE_WAYS; w > 0; w--) begin
      if (rd_rsp_o.hit_oh[w-1]) begin
        hit_way = w - 1;
      end
    end
    // no bank was read for a tag-only lookup
    rd_rsp_o.data = tag_only_q ? '0 : way_words[hit_way];
  end

endmodule

// ==== verilog/dcache_mem.sv ====
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_mem (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  dcache_geom_pkg::port_vec_t                        rd_valid_i,
  input  dcache_port_pkg::rd_req_t [`DCACHE_NUM_PORTS-1:0]  rd_req_i,
  input  dcache_geom_pkg::tag_t [`DCACHE_NUM_PORTS-1:0]     rd_tag_i,
  output dcache_geom_pkg::port_vec_t                        rd_ack_o,
  output dcache_port_pkg::rd_rsp_t                          rd_rsp_o,
  input  dcache_port_pkg::cl_wr_t                           cl_wr_i,
  input  dcache_port_pkg::word_wr_t                         word_wr_i,
  output logic                                              word_ack_o
);

  dcache_geom_pkg::port_vec_t                             rd_prio;
  logic                                                   gnt_valid;
  dcache_geom_pkg::port_idx_t                             gnt_idx;
  dcache_port_pkg::rd_req_t                               gnt_req;
  dcache_port_pkg::bank_cmd_t [`DCACHE_NUM_BANKS-1:0]     bank_cmd;
  dcache_port_pkg::tag_cmd_t                              tag_cmd;
  dcache_geom_pkg::tag_entry_t [`DCACHE_WAYS-1:0]         tag_rdata;
  dcache_geom_pkg::way_words_t [`DCACHE_NUM_BANKS-1:0]    bank_rdata;

  ////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////

  for (genvar p = 0; p < `DCACHE_NUM_PORTS; p++) begin : gen_prio
    assign rd_prio[p] = rd_req_i[p].prio;
  end

  dcache_port_arbiter i_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_valid_i  (rd_valid_i),
    .rd_prio_i   (rd_prio),
    .block_i     (cl_wr_i.vld),
    .gnt_o       (rd_ack_o),
    .gnt_valid_o (gnt_valid),
    .gnt_idx_o   (gnt_idx)
  );

  // request of the winning port
  assign gnt_req = rd_req_i[gnt_idx];

  dcache_bank_ctrl i_bank_ctrl (
    .gnt_valid_i (gnt_valid),
    .gnt_req_i   (gnt_req),
    .cl_wr_i     (cl_wr_i),
    .word_wr_i   (word_wr_i),
    .word_ack_o  (word_ack_o),
    .bank_cmd_o  (bank_cmd),
    .tag_cmd_o   (tag_cmd)
  );

  ////////////////////////////////////////
  // arrays
  ////////////////////////////////////////

  // bank k holds word k of the line for every way
  for (genvar k = 0; k < `DCACHE_NUM_BANKS; k++) begin : gen_data_bank
    dcache_sram #(
      .NumWords  (`DCACHE_SETS),
      .payload_t (dcache_geom_pkg::way_words_t)
    ) i_data_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (bank_cmd[k].req),
      .we_i    (bank_cmd[k].we),
      .addr_i  (bank_cmd[k].idx),
      .wdata_i (bank_cmd[k].wdata),
      .be_i    (bank_cmd[k].be),
      .rdata_o (bank_rdata[k])
    );
  end

  // valid bit and tag, one array per way
  for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : gen_tag_way
    dcache_sram #(
      .NumWords  (`DCACHE_SETS),
      .payload_t (dcache_geom_pkg::tag_entry_t)
    ) i_tag_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (tag_cmd.req[w]),
      .we_i    (tag_cmd.we),
      .addr_i  (tag_cmd.idx),
      .wdata_i (tag_cmd.wdata[w]),
      .be_i    ('1),
      .rdata_o (tag_rdata[w])
    );
  end

  dcache_hit_select i_hit_select (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .gnt_valid_i    (gnt_valid),
    .gnt_tag_only_i (gnt_req.tag_only),
    .gnt_idx_i      (gnt_idx),
    .gnt_off_i      (gnt_req.off),
    .rd_tag_i       (rd_tag_i),
    .tag_rdata_i    (tag_rdata),
    .bank_rdata_i   (bank_rdata),
    .rd_rsp_o       (rd_rsp_o)
  );

endmodule

// ==== tb/dcache_mem_props.sv ====
`timescale 1ns/1ps

module dcache_mem_props (
  input logic                       clk_i,
  input logic                       rst_ni,
  input dcache_geom_pkg::port_vec_t rd_valid_i,
  input dcache_geom_pkg::port_vec_t rd_ack_o,
  input dcache_port_pkg::rd_rsp_t   rd_rsp_o,
  input dcache_port_pkg::cl_wr_t    cl_wr_i,
  input dcache_port_pkg::word_wr_t  word_wr_i,
  input logic                       word_ack_o
);

  int unsigned assert_errs = 0;

  // at most one way hits
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_rsp_o.hit_oh))
    else begin
      $error("hit_oh has more than one bit set");
      assert_errs++;
    end

  ack_on_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_ack_o) && ((rd_ack_o & ~rd_valid_i) == '0))
    else begin
      $error("rd_ack_o not one-hot or given to an idle port");
      assert_errs++;
    end

  // refill owns the arrays
  no_ack_in_refill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cl_wr_i.vld |-> (rd_ack_o == '0))
    else begin
      $error("read acknowledged during a refill");
      assert_errs++;
    end

  word_ack_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    word_ack_o |-> $onehot(word_wr_i.req))
    else begin
      $error("word write acknowledged with a way request that is not one-hot");
      assert_errs++;
    end

endmodule

bind dcache_mem dcache_mem_props i_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .rd_valid_i (rd_valid_i),
  .rd_ack_o   (rd_ack_o),
  .rd_rsp_o   (rd_rsp_o),
  .cl_wr_i    (cl_wr_i),
  .word_wr_i  (word_wr_i),
  .word_ack_o (word_ack_o)
);

// ==== tb/dcache_mem_tb.sv ====
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_mem_tb;

  localparam int unsigned WordBytes = `DCACHE_WORD_W / 8;

  // one read port as driven by the testbench with its late tag
  typedef struct packed {
    logic                     v;
    dcache_port_pkg::rd_req_t r;
    dcache_geom_pkg::tag_t    t;
  } port_drv_t;

  typedef struct packed {
    dcache_port_pkg::cl_wr_t           cl;
    dcache_port_pkg::word_wr_t         ww;
    port_drv_t [`DCACHE_NUM_PORTS-1:0] p;
    dcache_geom_pkg::port_vec_t        exp_ack;
    logic                              exp_wack;
  } step_t;

  logic                                             clk_i;
  logic                                             rst_ni;
  dcache_geom_pkg::port_vec_t                       rd_valid_i;
  dcache_port_pkg::rd_req_t [`DCACHE_NUM_PORTS-1:0] rd_req_i;
  dcache_geom_pkg::tag_t [`DCACHE_NUM_PORTS-1:0]    rd_tag_i;
  dcache_geom_pkg::port_vec_t                       rd_ack_o;
  dcache_port_pkg::rd_rsp_t                         rd_rsp_o;
  dcache_port_pkg::cl_wr_t                          cl_wr_i;
  dcache_port_pkg::word_wr_t                        word_wr_i;
  logic                                             word_ack_o;

  // reference model of the arrays
  dcache_geom_pkg::tag_t m_tag  [`DCACHE_WAYS][`DCACHE_SETS];
  logic                  m_vld  [`DCACHE_WAYS][`DCACHE_SETS];
  dcache_geom_pkg::word_t m_word [`DCACHE_WAYS][`DCACHE_SETS][`DCACHE_NUM_BANKS];

  step_t       steps[$];
  int unsigned errs = 0;
  int unsigned cycles = 0;
  int unsigned max_cycles = 0;

  dcache_mem dcache_mem_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_valid_i (rd_valid_i),
    .rd_req_i   (rd_req_i),
    .rd_tag_i   (rd_tag_i),
    .rd_ack_o   (rd_ack_o),
    .rd_rsp_o   (rd_rsp_o),
    .cl_wr_i    (cl_wr_i),
    .word_wr_i  (word_wr_i),
    .word_ack_o (word_ack_o)
  );

  initial begin : p_clk
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // cycle limit
  initial begin : p_timeout
    wait (max_cycles != 0);
    while (cycles < max_cycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: the step table did not complete within %0d cycles", max_cycles);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////
  // table helpers
  ////////////////////////////////////////

  function automatic dcache_port_pkg::cl_wr_t line_fill(dcache_geom_pkg::way_vec_t we,
      dcache_geom_pkg::tag_t tag, dcache_geom_pkg::idx_t idx,
      dcache_geom_pkg::way_vec_t vbits);
    dcache_port_pkg::cl_wr_t c;
    c          = '0;
    c.vld      = 1'b1;
    c.we       = we;
    c.tag      = tag;
    c.idx      = idx;
    c.vld_bits = vbits;
    c.be       = '1;
    for (int k = 0; k < `DCACHE_NUM_BANKS; k++) begin
      c.data[k] = $urandom();
    end
    return c;
  endfunction

  function automatic dcache_port_pkg::word_wr_t word_store(dcache_geom_pkg::way_vec_t req,
      dcache_geom_pkg::idx_t idx, dcache_geom_pkg::off_t off, dcache_geom_pkg::word_t data,
      dcache_geom_pkg::word_be_t be);
    dcache_port_pkg::word_wr_t w;
    w.req  = req;
    w.idx  = idx;
    w.off  = off;
    w.data = data;
    w.be   = be;
    return w;
  endfunction

  function automatic port_drv_t port_read(dcache_geom_pkg::idx_t idx,
      dcache_geom_pkg::off_t off, logic tag_only, logic prio, dcache_geom_pkg::tag_t tag);
    port_drv_t d;
    d.v          = 1'b1;
    d.r.idx      = idx;
    d.r.off      = off;
    d.r.tag_only = tag_only;
    d.r.prio     = prio;
    d.t          = tag;
    return d;
  endfunction

  task automatic add_step(dcache_port_pkg::cl_wr_t cl, dcache_port_pkg::word_wr_t ww,
      port_drv_t p0, port_drv_t p1, port_drv_t p2, dcache_geom_pkg::port_vec_t ack,
      logic wack);
    step_t s;
    s.cl       = cl;
    s.ww       = ww;
    s.p[0]     = p0;
    s.p[1]     = p1;
    s.p[2]     = p2;
    s.exp_ack  = ack;
    s.exp_wack = wack;
    steps.push_back(s);
  endtask

  task automatic build_table();
    // refills of sets 1 and 2 per way with set 3 way 1 and set 4 left invalid
    add_step(line_fill(2'b01, 8'h11, 4'd1, 2'b11), '0, '0, '0, '0, 3'b000, 1'b0);
    add_step(line_fill(2'b10, 8'h22, 4'd1, 2'b11), '0, '0, '0, '0, 3'b000, 1'b0);
    add_step(line_fill(2'b01, 8'h33, 4'd2, 2'b11), '0, '0, '0, '0, 3'b000, 1'b0);
    add_step(line_fill(2'b10, 8'h44, 4'd2, 2'b11), '0, '0, '0, '0, 3'b000, 1'b0);
    add_step(line_fill(2'b11, 8'h55, 4'd3, 2'b01), '0, '0, '0, '0, 3'b000, 1'b0);
    add_step(line_fill(2'b11, 8'h66, 4'd4, 2'b00), '0, '0, '0, '0, 3'b000, 1'b0);
    // every bank of sets 1 and 2
    add_step('0, '0, port_read(4'd1, 4'd0, 1'b0, 1'b0, 8'h11), '0, '0, 3'b001, 1'b0);
    add_step('0, '0, '0, port_read(4'd1, 4'd4, 1'b0, 1'b0, 8'h22), '0, 3'b010, 1'b0);
    add_step('0, '0, '0, '0, port_read(4'd1, 4'd8, 1'b0, 1'b0, 8'h11), 3'b100, 1'b0);
    add_step('0, '0, port_read(4'd1, 4'd12, 1'b0, 1'b0, 8'h22), '0, '0, 3'b001, 1'b0);
    add_step('0, '0, '0, port_read(4'd2, 4'd0, 1'b0, 1'b0, 8'h44), '0, 3'b010, 1'b0);
    add_step('0, '0, '0, '0, port_read(4'd2, 4'd4, 1'b0, 1'b0, 8'h33), 3'b100, 1'b0);
    add_step('0, '0, port_read(4'd2, 4'd8, 1'b0, 1'b0, 8'h44), '0, '0, 3'b001, 1'b0);
    add_step('0, '0, '0, port_read(4'd2, 4'd12, 1'b0, 1'b0, 8'h33), '0, 3'b010, 1'b0);
    // misses, invalid ways and a tag-only lookup
    add_step('0, '0, '0, '0, port_read(4'd1, 4'd4, 1'b0, 1'b0, 8'h99), 3'b100, 1'b0);
    add_step('0, '0, port_read(4'd4, 4'd4, 1'b0, 1'b0, 8'h66), '0, '0, 3'b001, 1'b0);
    add_step('0, '0, '0, port_read(4'd2, 4'd8, 1'b1, 1'b0, 8'h44), '0, 3'b010, 1'b0);
    add_step('0, '0, '0, '0, port_read(4'd3, 4'd0, 1'b0, 1'b0, 8'h55), 3'b100, 1'b0);
    // arbitration starts with the pointer at port 0
    add_step('0, '0, port_read(4'd1, 4'd0, 1'b0, 1'b0, 8'h11),
             port_read(4'd2, 4'd0, 1'b0, 1'b0, 8'h33),
             port_read(4'd3, 4'd4, 1'b0, 1'b0, 8'h55), 3'b001, 1'b0);
    add_step('0, '0, port_read(4'd1, 4'd4, 1'b0, 1'b0, 8'h11),
             port_read(4'd2, 4'd0, 1'b0, 1'b0, 8'h33),
             port_read(4'd3, 4'd4, 1'b0, 1'b0, 8'h55), 3'b010, 1'b0);
    add_step('0, '0, port_read(4'd1, 4'd4, 1'b0, 1'b0, 8'h11),
             port_read(4'd2, 4'd4, 1'b0, 1'b1, 8'h44),
             port_read(4'd3, 4'd4, 1'b0, 1'b0, 8'h55), 3'b010, 1'b0);
    add_step('0, '0, port_read(4'd1, 4'd4, 1'b0, 1'b0, 8'h11),
             port_read(4'd1, 4'd8, 1'b0, 1'b1, 8'h22),
             port_read(4'd3, 4'd4, 1'b0, 1'b0, 8'h55), 3'b010, 1'b0);
    add_step('0, '0, port_read(4'd1, 4'd4, 1'b0, 1'b0, 8'h11), '0,
             port_read(4'd3, 4'd4, 1'b0, 1'b0, 8'h55), 3'b100, 1'b0);
    add_step('0, '0, port_read(4'd1, 4'd4, 1'b0, 1'b0, 8'h11),
             port_read(4'd1, 4'd12, 1'b0, 1'b0, 8'h22),
             port_read(4'd2, 4'd12, 1'b0, 1'b0, 8'h33), 3'b001, 1'b0);
    add_step('0, '0, '0, port_read(4'd1, 4'd12, 1'b0, 1'b0, 8'h22),
             port_read(4'd2, 4'd12, 1'b0, 1'b0, 8'h33), 3'b010, 1'b0);
    add_step('0, '0, '0, '0, port_read(4'd2, 4'd12, 1'b0, 1'b0, 8'h33), 3'b100, 1'b0);
    add_step('0, '0, port_read(4'd3, 4'd0, 1'b0, 1'b0, 8'h55), '0,
             port_read(4'd1, 4'd0, 1'b0, 1'b1, 8'h11), 3'b100, 1'b0);
    add_step('0, '0, port_read(4'd3, 4'd0, 1'b0, 1'b0, 8'h55), '0, '0, 3'b001, 1'b0);
    // word writes next to reads
    add_step('0, word_store(2'b01, 4'd1, 4'd4, 32'hA5A5_5A5A, 4'b0101),
             port_read(4'd1, 4'd0, 1'b0, 1'b0, 8'h11), '0, '0, 3'b001, 1'b1);
    add_step('0, '0, '0, port_read(4'd1, 4'd4, 1'b0, 1'b0, 8'h11), '0, 3'b010, 1'b0);
    add_step('0, word_store(2'b10, 4'd2, 4'd8, 32'h1234_5678, 4'b1100), '0, '0,
             port_read(4'd2, 4'd8, 1'b1, 1'b0, 8'h44), 3'b100, 1'b1);
    add_step('0, '0, port_read(4'd2, 4'd8, 1'b0, 1'b0, 8'h44), '0, '0, 3'b001, 1'b0);
    add_step('0, word_store(2'b10, 4'd1, 4'd12, 32'hDEAD_BEEF, 4'b1111), '0,
             port_read(4'd1, 4'd12, 1'b0, 1'b0, 8'h22), '0, 3'b010, 1'b0);
    add_step('0, word_store(2'b10, 4'd1, 4'd12, 32'hDEAD_BEEF, 4'b1111), '0, '0, '0,
             3'b000, 1'b1);
    add_step('0, '0, '0, '0, port_read(4'd1, 4'd12, 1'b0, 1'b0, 8'h22), 3'b100, 1'b0);
    // refill stalls reads and the word write
    add_step(line_fill(2'b11, 8'h77, 4'd5, 2'b01),
             word_store(2'b01, 4'd2, 4'd0, 32'hCAFE_F00D, 4'b1001),
             port_read(4'd1, 4'd0, 1'b0, 1'b0, 8'h11),
             port_read(4'd2, 4'd4, 1'b0, 1'b0, 8'h44), '0, 3'b000, 1'b0);
    add_step('0, word_store(2'b01, 4'd2, 4'd0, 32'hCAFE_F00D, 4'b1001),
             port_read(4'd1, 4'd0, 1'b0, 1'b0, 8'h11),
             port_read(4'd2, 4'd4, 1'b0, 1'b0, 8'h44), '0, 3'b001, 1'b0);
    add_step('0, word_store(2'b01, 4'd2, 4'd0, 32'hCAFE_F00D, 4'b1001), '0,
             port_read(4'd2, 4'd4, 1'b0, 1'b0, 8'h44), '0, 3'b010, 1'b1);
    add_step('0, '0, '0, '0, port_read(4'd5, 4'd0, 1'b0, 1'b0, 8'h77), 3'b100, 1'b0);
    add_step('0, '0, port_read(4'd2, 4'd0, 1'b0, 1'b0, 8'h33), '0, '0, 3'b001, 1'b0);
  endtask

  ////////////////////////////////////////
  // model and checks
  ////////////////////////////////////////

  function automatic dcache_port_pkg::rd_rsp_t expect_rsp(port_drv_t d);
    dcache_port_pkg::rd_rsp_t r;
    int unsigned              way;
    int unsigned              bank;
    way  = 0;
    bank = 32'(d.r.off) / WordBytes;
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      r.vld_bits[w] = m_vld[w][d.r.idx];
      r.hit_oh[w]   = m_vld[w][d.r.idx] && (m_tag[w][d.r.idx] == d.t);
    end
    for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
      if (r.hit_oh[w]) begin
        way = w;
      end
    end
    r.data = m_word[way][d.r.idx][bank];
    return r;
  endfunction

  task automatic update_model(step_t s);
    int unsigned bank;
    bank = 32'(s.ww.off) / WordBytes;
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      if (s.cl.vld && s.cl.we[w]) begin
        m_tag[w][s.cl.idx] = s.cl.tag;
        m_vld[w][s.cl.idx] = s.cl.vld_bits[w];
        for (int k = 0; k < `DCACHE_NUM_BANKS; k++) begin
          m_word[w][s.cl.idx][k] = s.cl.data[k];
        end
      end
      // only the enabled bytes of an accepted word write change
      if (s.exp_wack && s.ww.req[w]) begin
        for (int b = 0; b < WordBytes; b++) begin
          if (s.ww.be[b]) begin
            m_word[w][s.ww.idx][bank][8*b +: 8] = s.ww.data[8*b +: 8];
          end
        end
      end
    end
  endtask

  task automatic check_ack(dcache_geom_pkg::port_vec_t exp, dcache_geom_pkg::port_vec_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t rd_ack_o expected %b actual %b", $time, exp, act);
      errs++;
    end
  endtask

  task automatic check_word_ack(logic exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t word_ack_o expected %b actual %b", $time, exp, act);
      errs++;
    end
  endtask

  task automatic check_rsp(dcache_port_pkg::rd_rsp_t exp, dcache_port_pkg::rd_rsp_t act,
      logic granted, logic tag_only);
    if (act.hit_oh !== exp.hit_oh) begin
      $display("[ERROR] %0t rd_rsp_o.hit_oh expected %b actual %b", $time, exp.hit_oh,
               act.hit_oh);
      errs++;
    end
    if (granted && (act.vld_bits !== exp.vld_bits)) begin
      $display("[ERROR] %0t rd_rsp_o.vld_bits expected %b actual %b", $time, exp.vld_bits,
               act.vld_bits);
      errs++;
    end
    if (granted && !tag_only && (act.data !== exp.data)) begin
      $display("[ERROR] %0t rd_rsp_o.data expected %h actual %h", $time, exp.data, act.data);
      errs++;
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : p_main
    step_t                    cur;
    step_t                    prev;
    dcache_port_pkg::rd_rsp_t exp_rsp;
    logic                     was_gnt;
    logic                     was_tag_only;
    void'($urandom(32'he4b9_5563));
    rst_ni     = 1'b0;
    rd_valid_i = '0;
    rd_req_i   = '0;
    rd_tag_i   = '0;
    cl_wr_i    = '0;
    word_wr_i  = '0;
    build_table();
    max_cycles = 2 * steps.size() + 100;
    repeat (16) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    prev         = '0;
    exp_rsp      = '0;
    was_gnt      = 1'b0;
    was_tag_only = 1'b0;
    // one extra idle step checks the last response
    for (int n = 0; n <= steps.size(); n++) begin
      cur = '0;
      if (n < steps.size()) begin
        cur = steps[n];
      end
      @(posedge clk_i);
      #1;
      cl_wr_i   = cur.cl;
      word_wr_i = cur.ww;
      for (int p = 0; p < `DCACHE_NUM_PORTS; p++) begin
        rd_valid_i[p] = cur.p[p].v;
        rd_req_i[p]   = cur.p[p].r;
        rd_tag_i[p]   = prev.p[p].t;
      end
      #5;
      check_ack(cur.exp_ack, rd_ack_o);
      check_word_ack(cur.exp_wack, word_ack_o);
      check_rsp(exp_rsp, rd_rsp_o, was_gnt, was_tag_only);
      was_gnt      = |cur.exp_ack;
      was_tag_only = 1'b0;
      exp_rsp      = '0;
      for (int p = 0; p < `DCACHE_NUM_PORTS; p++) begin
        if (cur.exp_ack[p]) begin
          exp_rsp      = expect_rsp(cur.p[p]);
          was_tag_only = cur.p[p].r.tag_only;
        end
      end
      update_model(cur);
      prev = cur;
    end
    $display("checks done: %0d compare errors, %0d assertion errors", errs,
             dcache_mem_inst.i_props.assert_errs);
    if (errs == 0 && dcache_mem_inst.i_props.assert_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== dcache_mem.f ====
+incdir+verilog
verilog/dcache_geom_pkg.sv
verilog/dcache_port_pkg.sv
verilog/dcache_sram.sv
verilog/dcache_port_arbiter.sv
verilog/dcache_bank_ctrl.sv
verilog/dcache_hit_select.sv
verilog/dcache_mem.sv
tb/dcache_mem_props.sv
tb/dcache_mem_tb.sv

// ==== Bender.yml ====
package:
  name: dcache_mem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcache_geom_pkg.sv
      - verilog/dcache_port_pkg.sv
      - verilog/dcache_sram.sv
      - verilog/dcache_port_arbiter.sv
      - verilog/dcache_bank_ctrl.sv
      - verilog/dcache_hit_select.sv
      - verilog/dcache_mem.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/dcache_mem_props.sv
      - tb/dcache_mem_tb.sv
